// ==== common/ex_pkg.sv ====
package ex_pkg;

	typedef logic [31:0] word_t;
	typedef logic [63:0] dword_t;
	typedef logic [4:0]  reg_addr_t;

	// shift amount comes from the low bits of operand 1
	localparam int SHAMT_W = 5;

	// operation subtype from decode
	typedef enum logic [7:0] {
		EXE_NOP_OP   = 8'h00,
		EXE_SRL_OP   = 8'h02,
		EXE_SRA_OP   = 8'h03,
		EXE_MOVZ_OP  = 8'h0A,
		EXE_MOVN_OP  = 8'h0B,
		EXE_MFHI_OP  = 8'h10,
		EXE_MTHI_OP  = 8'h11,
		EXE_MFLO_OP  = 8'h12,
		EXE_MTLO_OP  = 8'h13,
		EXE_MULT_OP  = 8'h18,
		EXE_MULTU_OP = 8'h19,
		EXE_ADD_OP   = 8'h20,
		EXE_ADDU_OP  = 8'h21,
		EXE_SUB_OP   = 8'h22,
		EXE_SUBU_OP  = 8'h23,
		EXE_AND_OP   = 8'h24,
		EXE_OR_OP    = 8'h25,
		EXE_XOR_OP   = 8'h26,
		EXE_NOR_OP   = 8'h27,
		EXE_SLT_OP   = 8'h2A,
		EXE_SLTU_OP  = 8'h2B,
		EXE_ADDI_OP  = 8'h55,
		EXE_ADDIU_OP = 8'h56,
		EXE_SLTI_OP  = 8'h57,
		EXE_SLTIU_OP = 8'h58,
		EXE_SLL_OP   = 8'h7C,
		EXE_MUL_OP   = 8'hA9,
		EXE_CLZ_OP   = 8'hB0,
		EXE_CLO_OP   = 8'hB1
	} aluop_t;

	// result class, picks which unit feeds the write data
	typedef enum logic [2:0] {
		EXE_RES_NOP        = 3'd0,
		EXE_RES_LOGIC      = 3'd1,
		EXE_RES_SHIFT      = 3'd2,
		EXE_RES_MOVE       = 3'd3,
		EXE_RES_ARITHMETIC = 3'd4
	} alusel_t;

endpackage

// ==== source/hilo_forward.sv ====
`timescale 1ns/1ps

module hilo_forward
	import ex_pkg::*;
(
	input  word_t hi_i,
	input  word_t lo_i,
	input  logic  mem_whilo_i,
	input  word_t mem_hi_i,
	input  word_t mem_lo_i,
	input  logic  wb_whilo_i,
	input  word_t wb_hi_i,
	input  word_t wb_lo_i,
	output word_t hi_o,
	output word_t lo_o
);

	// newest pending write wins
	always_comb begin
		if (mem_whilo_i) begin
			hi_o = mem_hi_i;
			lo_o = mem_lo_i;
		end else if (wb_whilo_i) begin
			hi_o = wb_hi_i;
			lo_o = wb_lo_i;
		end else begin
			// nothing in flight, register file is current
			hi_o = hi_i;
			lo_o = lo_i;
		end
	end

endmodule

// ==== alu/alu_logic_shift_move.sv ====
`timescale 1ns/1ps

module alu_logic_shift_move
	import ex_pkg::*;
(
	input  aluop_t aluop_i,
	input  word_t  reg1_i,
	input  word_t  reg2_i,
	input  word_t  hi_i,
	input  word_t  lo_i,
	output word_t  logic_res_o,
	output word_t  shift_res_o,
	output word_t  move_res_o
);

	logic [SHAMT_W-1:0] shamt;

	assign shamt = reg1_i[SHAMT_W-1:0];

	// bitwise ops
	always_comb begin
		case (aluop_i)
			EXE_AND_OP: logic_res_o = reg1_i & reg2_i;
			EXE_OR_OP:  logic_res_o = reg1_i | reg2_i;
			EXE_XOR_OP: logic_res_o = reg1_i ^ reg2_i;
			EXE_NOR_OP: logic_res_o = ~(reg1_i | reg2_i);
			default:    logic_res_o = '0;
		endcase
	end

	// operand 2 is shifted, operand 1 holds the amount
	always_comb begin
		case (aluop_i)
			EXE_SLL_OP: shift_res_o = reg2_i << shamt;
			EXE_SRL_OP: shift_res_o = reg2_i >> shamt;
			EXE_SRA_OP: shift_res_o = word_t'($signed(reg2_i) >>> shamt);
			default:    shift_res_o = '0;
		endcase
	end

	// condition for movn/movz is resolved in decode
	always_comb begin
		case (aluop_i)
			EXE_MOVN_OP,
			EXE_MOVZ_OP: move_res_o = reg1_i;
			EXE_MFHI_OP: move_res_o = hi_i;
			EXE_MFLO_OP: move_res_o = lo_i;
			default:     move_res_o = '0;
		endcase
	end

endmodule

// ==== alu/alu_arith.sv ====
`timescale 1ns/1ps

module alu_arith
	import ex_pkg::*;
(
	input  aluop_t aluop_i,
	input  word_t  reg1_i,
	input  word_t  reg2_i,
	input  word_t  mul_lo_i,
	output word_t  arith_res_o,
	output logic   ovf_o
);

	word_t sum;
	word_t diff;
	logic  add_ovf;
	logic  sub_ovf;
	logic  lt_signed;
	logic  lt_unsigned;

	// leading run of bits equal to val, 0 to 32
	function automatic logic [5:0] lead_count(input word_t w, input logic val);
		logic [5:0] n;
		logic       run;
		n   = '0;
		run = 1'b1;
		for (int i = 31; i >= 0; i--) begin
			if (run && (w[i] == val)) begin
				n = n + 6'd1;
			end else begin
				run = 1'b0;
			end
		end
		return n;
	endfunction

	assign sum  = reg1_i + reg2_i;
	assign diff = reg1_i - reg2_i;

	// same-sign operands, result sign flipped
	assign add_ovf = (reg1_i[31] == reg2_i[31]) && (sum[31] != reg1_i[31]);
	// opposite-sign operands, result takes the subtrahend's sign
	assign sub_ovf = (reg1_i[31] != reg2_i[31]) && (diff[31] != reg1_i[31]);

	assign lt_signed   = $signed(reg1_i) < $signed(reg2_i);
	assign lt_unsigned = reg1_i < reg2_i;

	always_comb begin
		case (aluop_i)
			EXE_ADD_OP,
			EXE_ADDI_OP: ovf_o = add_ovf;
			EXE_SUB_OP:  ovf_o = sub_ovf;
			default:     ovf_o = 1'b0;
		endcase
	end

	// immediate forms already have the extended imm in operand 2
	always_comb begin
		case (aluop_i)
			EXE_ADD_OP,
			EXE_ADDU_OP,
			EXE_ADDI_OP,
			EXE_ADDIU_OP: arith_res_o = sum;
			EXE_SUB_OP,
			EXE_SUBU_OP:  arith_res_o = diff;
			EXE_SLT_OP,
			EXE_SLTI_OP:  arith_res_o = {31'b0, lt_signed};
			EXE_SLTU_OP,
			EXE_SLTIU_OP: arith_res_o = {31'b0, lt_unsigned};
			EXE_CLZ_OP:   arith_res_o = {26'b0, lead_count(reg1_i, 1'b0)};
			EXE_CLO_OP:   arith_res_o = {26'b0, lead_count(reg1_i, 1'b1)};
			EXE_MUL_OP:   arith_res_o = mul_lo_i;
			default:      arith_res_o = '0;
		endcase
	end

endmodule

// ==== alu/mul_hilo_unit.sv ====
`timescale 1ns/1ps

module mul_hilo_unit
	import ex_pkg::*;
(
	input  aluop_t aluop_i,
	input  word_t  reg1_i,
	input  word_t  reg2_i,
	input  word_t  hi_i,
	input  word_t  lo_i,
	output word_t  mul_lo_o,
	output logic   whilo_o,
	output word_t  hi_o,
	output word_t  lo_o
);

	dword_t prod_s;
	dword_t prod_u;

	// full 64-bit products, operands extended by their signedness
	assign prod_s = $signed(reg1_i) * $signed(reg2_i);
	assign prod_u = reg1_i * reg2_i;

	assign mul_lo_o = prod_s[31:0];

	always_comb begin
		whilo_o = 1'b1;
		hi_o    = hi_i;
		lo_o    = lo_i;
		case (aluop_i)
			EXE_MULT_OP:  {hi_o, lo_o} = prod_s;
			EXE_MULTU_OP: {hi_o, lo_o} = prod_u;
			// other half keeps the forwarded value
			EXE_MTHI_OP:  hi_o = reg1_i;
			EXE_MTLO_OP:  lo_o = reg1_i;
			default:      whilo_o = 1'b0;
		endcase
	end

endmodule

// ==== source/ex_mem_reg.sv ====
`timescale 1ns/1ps

module ex_mem_reg
	import ex_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n_i,
	input  alusel_t   alusel_i,
	input  reg_addr_t wd_i,
	input  logic      wreg_i,
	input  word_t     logic_res_i,
	input  word_t     shift_res_i,
	input  word_t     move_res_i,
	input  word_t     arith_res_i,
	input  logic      ovf_i,
	input  logic      whilo_i,
	input  word_t     hi_i,
	input  word_t     lo_i,
	output reg_addr_t mem_wd_o,
	output logic      mem_wreg_o,
	output word_t     mem_wdata_o,
	output logic      mem_whilo_o,
	output word_t     mem_hi_o,
	output word_t     mem_lo_o
);

	word_t wdata;

	// write data by result class
	always_comb begin
		case (alusel_i)
			EXE_RES_LOGIC:      wdata = logic_res_i;
			EXE_RES_SHIFT:      wdata = shift_res_i;
			EXE_RES_MOVE:       wdata = move_res_i;
			EXE_RES_ARITHMETIC: wdata = arith_res_i;
			default:            wdata = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			mem_wd_o    <= '0;
			mem_wreg_o  <= 1'b0;
			mem_wdata_o <= '0;
			mem_whilo_o <= 1'b0;
			mem_hi_o    <= '0;
			mem_lo_o    <= '0;
		end else begin
			mem_wd_o    <= wd_i;
			// signed overflow cancels the register write
			mem_wreg_o  <= wreg_i & ~ovf_i;
			mem_wdata_o <= wdata;
			mem_whilo_o <= whilo_i;
			mem_hi_o    <= hi_i;
			mem_lo_o    <= lo_i;
		end
	end

endmodule

// ==== source/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage
	import ex_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n_i,
	input  aluop_t    aluop_i,
	input  alusel_t   alusel_i,
	input  reg_addr_t wd_i,
	input  logic      wreg_i,
	input  word_t     reg1_i,
	input  word_t     reg2_i,
	input  word_t     hi_i,
	input  word_t     lo_i,
	input  logic      mem_whilo_i,
	input  word_t     mem_hi_i,
	input  word_t     mem_lo_i,
	input  logic      wb_whilo_i,
	input  word_t     wb_hi_i,
	input  word_t     wb_lo_i,
	output reg_addr_t mem_wd_o,
	output logic      mem_wreg_o,
	output word_t     mem_wdata_o,
	output logic      mem_whilo_o,
	output word_t     mem_hi_o,
	output word_t     mem_lo_o
);

	word_t cur_hi;
	word_t cur_lo;
	word_t logic_res;
	word_t shift_res;
	word_t move_res;
	word_t arith_res;
	logic  ovf;
	word_t mul_lo;
	logic  whilo;
	word_t new_hi;
	word_t new_lo;

	hilo_forward u_hilo_forward (
		.hi_i        (hi_i),
		.lo_i        (lo_i),
		.mem_whilo_i (mem_whilo_i),
		.mem_hi_i    (mem_hi_i),
		.mem_lo_i    (mem_lo_i),
		.wb_whilo_i  (wb_whilo_i),
		.wb_hi_i     (wb_hi_i),
		.wb_lo_i     (wb_lo_i),
		.hi_o        (cur_hi),
		.lo_o        (cur_lo)
	);

	alu_logic_shift_move u_alu_lsm (
		.aluop_i     (aluop_i),
		.reg1_i      (reg1_i),
		.reg2_i      (reg2_i),
		.hi_i        (cur_hi),
		.lo_i        (cur_lo),
		.logic_res_o (logic_res),
		.shift_res_o (shift_res),
		.move_res_o  (move_res)
	);

	mul_hilo_unit u_mul_hilo (
		.aluop_i  (aluop_i),
		.reg1_i   (reg1_i),
		.reg2_i   (reg2_i),
		.hi_i     (cur_hi),
		.lo_i     (cur_lo),
		.mul_lo_o (mul_lo),
		.whilo_o  (whilo),
		.hi_o     (new_hi),
		.lo_o     (new_lo)
	);

	alu_arith u_alu_arith (
		.aluop_i     (aluop_i),
		.reg1_i      (reg1_i),
		.reg2_i      (reg2_i),
		.mul_lo_i    (mul_lo),
		.arith_res_o (arith_res),
		.ovf_o       (ovf)
	);

	ex_mem_reg u_ex_mem_reg (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.alusel_i    (alusel_i),
		.wd_i        (wd_i),
		.wreg_i      (wreg_i),
		.logic_res_i (logic_res),
		.shift_res_i (shift_res),
		.move_res_i  (move_res),
		.arith_res_i (arith_res),
		.ovf_i       (ovf),
		.whilo_i     (whilo),
		.hi_i        (new_hi),
		.lo_i        (new_lo),
		.mem_wd_o    (mem_wd_o),
		.mem_wreg_o  (mem_wreg_o),
		.mem_wdata_o (mem_wdata_o),
		.mem_whilo_o (mem_whilo_o),
		.mem_hi_o    (mem_hi_o),
		.mem_lo_o    (mem_lo_o)
	);

endmodule

// ==== verif/ex_stage_sva.sv ====
`timescale 1ns/1ps

module ex_stage_sva
	import ex_pkg::*;
(
	input logic      clk,
	input logic      rst_n_i,
	input aluop_t    aluop_i,
	input reg_addr_t wd_i,
	input word_t     reg1_i,
	input word_t     reg2_i,
	input reg_addr_t mem_wd_o,
	input logic      mem_wreg_o,
	input logic      mem_whilo_o
);

	int          fail_cnt = 0;
	logic [32:0] sum_x;
	logic [32:0] diff_x;
	logic        ovf_op;
	logic        hilo_op;

	// sign-extended to 33 bits, top two bits differ on overflow
	assign sum_x  = {reg1_i[31], reg1_i} + {reg2_i[31], reg2_i};
	assign diff_x = {reg1_i[31], reg1_i} - {reg2_i[31], reg2_i};

	assign ovf_op = ((aluop_i == EXE_ADD_OP || aluop_i == EXE_ADDI_OP) && (sum_x[32] != sum_x[31]))
		|| (aluop_i == EXE_SUB_OP && (diff_x[32] != diff_x[31]));

	assign hilo_op = (aluop_i == EXE_MULT_OP) || (aluop_i == EXE_MULTU_OP)
		|| (aluop_i == EXE_MTHI_OP) || (aluop_i == EXE_MTLO_OP);

	enables_low_after_reset: assert property (@(posedge clk)
		!rst_n_i |=> !mem_wreg_o && !mem_whilo_o)
	else begin
		fail_cnt++;
		$error("write enable set in the cycle after reset");
	end

	whilo_only_after_hilo_op: assert property (@(posedge clk)
		$rose(mem_whilo_o) |-> $past(hilo_op && rst_n_i))
	else begin
		fail_cnt++;
		$error("hi/lo write request without a hi/lo operation");
	end

	overflow_cancels_write: assert property (@(posedge clk)
		rst_n_i && ovf_op |=> !mem_wreg_o)
	else begin
		fail_cnt++;
		$error("overflowing add or sub still writes the register");
	end

	wd_follows_input: assert property (@(posedge clk)
		rst_n_i |=> mem_wd_o == $past(wd_i))
	else begin
		fail_cnt++;
		$error("destination register not carried through");
	end

endmodule

// ==== verif/tb_ex_stage.sv ====
`timescale 1ns/1ps

module tb_ex_stage
	import ex_pkg::*;
();

	localparam int CLK_PERIOD   = 100;
	localparam int OPS_PER_TEST = 64;
	localparam int NUM_TESTS    = 6;
	localparam int TIMEOUT      = (NUM_TESTS * OPS_PER_TEST + 50) * CLK_PERIOD;
	localparam int unsigned SEED = 32'haca6_d545;

	localparam aluop_t LS_OPS [7] = '{EXE_AND_OP, EXE_OR_OP, EXE_XOR_OP, EXE_NOR_OP,
		EXE_SLL_OP, EXE_SRL_OP, EXE_SRA_OP};
	localparam aluop_t AS_OPS [6] = '{EXE_ADD_OP, EXE_ADDU_OP, EXE_SUB_OP, EXE_SUBU_OP,
		EXE_ADDI_OP, EXE_ADDIU_OP};
	localparam aluop_t CC_OPS [6] = '{EXE_SLT_OP, EXE_SLTI_OP, EXE_SLTU_OP, EXE_SLTIU_OP,
		EXE_CLZ_OP, EXE_CLO_OP};
	localparam aluop_t MH_OPS [5] = '{EXE_MUL_OP, EXE_MULT_OP, EXE_MULTU_OP, EXE_MTHI_OP,
		EXE_MTLO_OP};

	typedef struct packed {
		aluop_t    op;
		reg_addr_t wd;
		logic      wreg;
		logic      check_data;
		word_t     wdata;
		logic      whilo;
		word_t     hi;
		word_t     lo;
	} expect_t;

	logic      clk;
	logic      rst_n_i;
	aluop_t    aluop_i;
	alusel_t   alusel_i;
	reg_addr_t wd_i;
	logic      wreg_i;
	word_t     reg1_i;
	word_t     reg2_i;
	word_t     hi_i;
	word_t     lo_i;
	logic      mem_whilo_i;
	word_t     mem_hi_i;
	word_t     mem_lo_i;
	logic      wb_whilo_i;
	word_t     wb_hi_i;
	word_t     wb_lo_i;
	reg_addr_t mem_wd_o;
	logic      mem_wreg_o;
	word_t     mem_wdata_o;
	logic      mem_whilo_o;
	word_t     mem_hi_o;
	word_t     mem_lo_o;

	expect_t exp_q[$];
	int      test_errs;
	int      tests_passed;
	int      tests_failed;

	ex_stage UUT (.*);

	bind ex_stage ex_stage_sva u_sva (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TIMEOUT);
		$display("run timed out before all tests finished");
		$display("Test failed");
		$finish;
	end

	// corner values mixed into random operands
	function automatic word_t pick_operand();
		word_t r;
		r = $urandom();
		case (r[2:0])
			3'd0:    return '0;
			3'd1:    return '1;
			3'd2:    return 32'h7FFF_FFFF;
			3'd3:    return 32'h8000_0000;
			default: return $urandom();
		endcase
	endfunction

	function automatic aluop_t pick_op(input int id);
		word_t r;
		r = $urandom();
		case (id)
			1:       return LS_OPS[r % 7];
			2:       return AS_OPS[r % 6];
			3:       return CC_OPS[r % 6];
			4:       return MH_OPS[r % 5];
			default: return r[0] ? EXE_MFHI_OP : EXE_MFLO_OP;
		endcase
	endfunction

	// result class as decode would set it
	function automatic alusel_t class_of(input aluop_t op);
		case (op)
			EXE_AND_OP, EXE_OR_OP, EXE_XOR_OP, EXE_NOR_OP: return EXE_RES_LOGIC;
			EXE_SLL_OP, EXE_SRL_OP, EXE_SRA_OP:            return EXE_RES_SHIFT;
			EXE_MFHI_OP, EXE_MFLO_OP:                      return EXE_RES_MOVE;
			EXE_MULT_OP, EXE_MULTU_OP, EXE_MTHI_OP, EXE_MTLO_OP: return EXE_RES_NOP;
			default:                                       return EXE_RES_ARITHMETIC;
		endcase
	endfunction

	function automatic expect_t expected_result(input aluop_t op, input alusel_t sel,
		input reg_addr_t wd, input logic we, input word_t a, input word_t b,
		input word_t ch, input word_t cl);
		expect_t     e;
		word_t       res;
		logic [32:0] wide;
		logic [63:0] prod;
		int          n;
		e = '0;
		e.op = op;
		e.wd = wd;
		e.wreg = we;
		e.check_data = 1'b1;
		e.hi = ch;
		e.lo = cl;
		res = '0;
		n = 0;
		case (op)
			EXE_AND_OP:  res = a & b;
			EXE_OR_OP:   res = a | b;
			EXE_XOR_OP:  res = a ^ b;
			EXE_NOR_OP:  res = ~(a | b);
			EXE_SLL_OP:  res = b << a[4:0];
			EXE_SRL_OP:  res = b >> a[4:0];
			// vacated upper bits filled with the sign
			EXE_SRA_OP:  res = (b >> a[4:0]) | (b[31] ? ~(32'hFFFF_FFFF >> a[4:0]) : '0);
			EXE_MFHI_OP: res = ch;
			EXE_MFLO_OP: res = cl;
			EXE_ADD_OP, EXE_ADDI_OP, EXE_SUB_OP: begin
				if (op == EXE_SUB_OP) begin
					wide = {a[31], a} - {b[31], b};
				end else begin
					wide = {a[31], a} + {b[31], b};
				end
				res = wide[31:0];
				// 33-bit result not representable in 32 bits
				if (wide[32] != wide[31]) begin
					e.wreg = 1'b0;
					e.check_data = 1'b0;
				end
			end
			EXE_ADDU_OP, EXE_ADDIU_OP: res = a + b;
			EXE_SUBU_OP: res = a - b;
			EXE_SLT_OP, EXE_SLTI_OP: res = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
			EXE_SLTU_OP, EXE_SLTIU_OP: res = {31'b0, a < b};
			EXE_CLZ_OP, EXE_CLO_OP: begin
				while (n < 32 && a[31 - n] == (op == EXE_CLO_OP)) begin
					n++;
				end
				res = word_t'(n);
			end
			EXE_MUL_OP, EXE_MULT_OP: begin
				prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
				res = prod[31:0];
				if (op == EXE_MULT_OP) begin
					e.whilo = 1'b1;
					{e.hi, e.lo} = prod;
				end
			end
			EXE_MULTU_OP: begin
				e.whilo = 1'b1;
				{e.hi, e.lo} = {32'b0, a} * {32'b0, b};
			end
			EXE_MTHI_OP: begin
				e.whilo = 1'b1;
				e.hi = a;
			end
			EXE_MTLO_OP: begin
				e.whilo = 1'b1;
				e.lo = a;
			end
			default: res = '0;
		endcase
		e.wdata = (sel == EXE_RES_NOP) ? '0 : res;
		return e;
	endfunction

	task automatic set_idle();
		aluop_i     <= EXE_NOP_OP;
		alusel_i    <= EXE_RES_NOP;
		wd_i        <= '0;
		wreg_i      <= 1'b0;
		reg1_i      <= '0;
		reg2_i      <= '0;
		hi_i        <= '0;
		lo_i        <= '0;
		mem_whilo_i <= 1'b0;
		mem_hi_i    <= '0;
		mem_lo_i    <= '0;
		wb_whilo_i  <= 1'b0;
		wb_hi_i     <= '0;
		wb_lo_i     <= '0;
	endtask

	task automatic issue_op(input aluop_t op, output expect_t e);
		word_t   a;
		word_t   b;
		word_t   hr;
		word_t   lr;
		word_t   mh;
		word_t   ml;
		word_t   wh;
		word_t   wl;
		word_t   r;
		word_t   ch;
		word_t   cl;
		alusel_t sel;
		a = pick_operand();
		b = pick_operand();
		hr = $urandom();
		lr = $urandom();
		mh = $urandom();
		ml = $urandom();
		wh = $urandom();
		wl = $urandom();
		r = $urandom();
		// memory stage beats write-back, write-back beats the register file
		ch = r[0] ? mh : (r[1] ? wh : hr);
		cl = r[0] ? ml : (r[1] ? wl : lr);
		sel = class_of(op);
		e = expected_result(op, sel, r[8:4], r[2], a, b, ch, cl);
		@(posedge clk);
		aluop_i     <= op;
		alusel_i    <= sel;
		wd_i        <= r[8:4];
		wreg_i      <= r[2];
		reg1_i      <= a;
		reg2_i      <= b;
		hi_i        <= hr;
		lo_i        <= lr;
		mem_whilo_i <= r[0];
		mem_hi_i    <= mh;
		mem_lo_i    <= ml;
		wb_whilo_i  <= r[1];
		wb_hi_i     <= wh;
		wb_lo_i     <= wl;
	endtask

	task automatic check_result(input expect_t e);
		aluop_t op;
		op = e.op;
		assert (mem_wd_o === e.wd && mem_wreg_o === e.wreg && mem_whilo_o === e.whilo)
		else begin
			$display("MISMATCH at %0t: %s enables or address wrong", $time, op.name());
			test_errs++;
		end
		assert (mem_hi_o === e.hi && mem_lo_o === e.lo)
		else begin
			$display("MISMATCH at %0t: %s hi/lo %h/%h, expected %h/%h", $time, op.name(),
				mem_hi_o, mem_lo_o, e.hi, e.lo);
			test_errs++;
		end
		assert (!e.check_data || mem_wdata_o === e.wdata)
		else begin
			$display("MISMATCH at %0t: %s data %h, expected %h", $time, op.name(),
				mem_wdata_o, e.wdata);
			test_errs++;
		end
	endtask

	task automatic check_reset_outputs();
		assert (mem_wreg_o === 1'b0 && mem_whilo_o === 1'b0 && mem_wdata_o === '0)
		else begin
			$display("MISMATCH at %0t: reset, outputs not cleared", $time);
			test_errs++;
		end
	endtask

	task automatic report_test(input string name, input int n_ops);
		$display("%-12s %0d ops, %0d mismatches, %s", name, n_ops, test_errs,
			(test_errs == 0) ? "pass" : "fail");
		if (test_errs == 0) begin
			tests_passed++;
		end else begin
			tests_failed++;
		end
	endtask

	task automatic run_test(input int id, input string name);
		expect_t e_new;
		aluop_t  op;
		test_errs = 0;
		for (int i = 0; i < OPS_PER_TEST; i++) begin
			op = pick_op(id);
			issue_op(op, e_new);
			// outputs now hold the op issued one cycle earlier
			@(negedge clk);
			if (exp_q.size() > 0) begin
				check_result(exp_q.pop_front());
			end
			exp_q.push_back(e_new);
		end
		@(posedge clk);
		set_idle();
		@(negedge clk);
		check_result(exp_q.pop_front());
		report_test(name, OPS_PER_TEST);
	endtask

	initial begin
		void'($urandom(SEED));
		tests_passed = 0;
		tests_failed = 0;
		rst_n_i = 1'b0;
		set_idle();
		test_errs = 0;
		for (int i = 0; i < 3; i++) begin
			@(posedge clk);
			if (i == 1) begin
				rst_n_i <= 1'b1;
			end
			@(negedge clk);
			check_reset_outputs();
		end
		report_test("reset", 3);
		run_test(1, "logic_shift");
		run_test(2, "add_sub");
		run_test(3, "cmp_count");
		run_test(4, "mul_hilo");
		run_test(5, "hilo_fwd");
		$display("tests passed %0d, failed %0d, assertion failures %0d",
			tests_passed, tests_failed, UUT.u_sva.fail_cnt);
		if (tests_failed == 0 && UUT.u_sva.fail_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== ex_stage.f ====
common/ex_pkg.sv
source/hilo_forward.sv
alu/alu_logic_shift_move.sv
alu/alu_arith.sv
alu/mul_hilo_unit.sv
source/ex_mem_reg.sv
source/ex_stage.sv
verif/ex_stage_sva.sv
verif/tb_ex_stage.sv

// ==== Makefile ====
SIM        ?= verilator
TOP        ?= tb_ex_stage
FILELIST   ?= ex_stage.f
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
